/* pipelineCore.f */
riscvCorePkg.sv
registerFile.sv
decodeExecuteReg.sv
aluUnit.sv
executeStage.sv
memoryWritebackStage.sv
hazardUnit.sv
pipelineCore.sv
pipelineCore_checker.sv
pipelineCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipelineCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module pipelineCore_tb \
   -f pipelineCore.f \
   -o pipelineCore_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/pipelineCore_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
   exit 1
fi
exit 0

/* pipelineCore_tb.sv */
`timescale 1ns/1ps

module pipelineCore_tb import riscvCorePkg::*; ();

   localparam int NUM_INSTR   = 400;
   localparam int MAX_STALL   = 4;
   localparam int DRAIN_LIMIT = 12;

   logic       clk;
   logic       rst;
   regAddr_t   rs1D;
   regAddr_t   rs2D;
   regAddr_t   rdD;
   word_t      immExtD;
   word_t      pcD;
   logic       regWriteD;
   logic       aluSrcD;
   logic       memWriteD;
   logic       jumpD;
   logic       branchD;
   resultSel_t resultSrcD;
   aluCtrl_t   aluControlD;
   logic       stallD;
   logic       pcSrcE;
   word_t      pcTargetE;
   logic       regWriteW;
   regAddr_t   rdW;
   word_t      resultW;

   // Architectural state and pending writebacks.
   word_t      modelRegs [32];
   word_t      modelMem [16];
   regAddr_t   expRd [$];
   word_t      expVal [$];
   int         expDue [$];
   int         cycle;
   word_t      pc;
   logic       draining;

   // What the model expects in the execute stage.
   logic       loadInE;
   regAddr_t   rdInE;
   logic       redirectDue;
   word_t      targetDue;

   pipelineCore #(
      .MEM_WORDS (256)
   ) uut (
      .clk         (clk),
      .rst         (rst),
      .rs1D        (rs1D),
      .rs2D        (rs2D),
      .rdD         (rdD),
      .immExtD     (immExtD),
      .pcD         (pcD),
      .regWriteD   (regWriteD),
      .aluSrcD     (aluSrcD),
      .memWriteD   (memWriteD),
      .jumpD       (jumpD),
      .branchD     (branchD),
      .resultSrcD  (resultSrcD),
      .aluControlD (aluControlD),
      .stallD      (stallD),
      .pcSrcE      (pcSrcE),
      .pcTargetE   (pcTargetE),
      .regWriteW   (regWriteW),
      .rdW         (rdW),
      .resultW     (resultW)
   );

   bind pipelineCore pipelineCore_checker controlChecks (
      .clk       (clk),
      .rst       (rst),
      .flushE    (flushE),
      .regWriteE (regWriteE),
      .memWriteE (memWriteE),
      .regWriteW (regWriteW),
      .rdW       (rdW),
      .stallD    (stallD),
      .forwardA  (forwardA),
      .forwardB  (forwardB)
   );

   always #20 clk = ~clk;

   function automatic word_t expectedAlu(input aluCtrl_t op, input word_t a, input word_t b);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         default: return '0;
      endcase
   endfunction

   task automatic reportError(input string msg);
      $display("Error: at %0t: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic reportTimeout(input string what);
      $display("Timeout: %s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic setBubble();
      rs1D        = '0;
      rs2D        = '0;
      rdD         = '0;
      immExtD     = '0;
      regWriteD   = 1'b0;
      aluSrcD     = 1'b0;
      memWriteD   = 1'b0;
      jumpD       = 1'b0;
      branchD     = 1'b0;
      resultSrcD  = RES_ALU;
      aluControlD = ALU_ADD;
   endtask

   // Registers x0 to x7, loads and stores on x0 plus word 0 to 15.
   task automatic randomizeInputs();
      int    kind;
      int    word;
      word_t r;
      kind = int'($urandom % 16);
      word = int'($urandom % 16);
      r    = $urandom;
      setBubble();
      rs1D    = regAddr_t'($urandom % 8);
      rs2D    = regAddr_t'($urandom % 8);
      rdD     = regAddr_t'($urandom % 8);
      immExtD = {{20{r[11]}}, r[11:0]};
      if (kind < 9) begin
         regWriteD   = 1'b1;
         aluSrcD     = (kind >= 6);
         aluControlD = aluCtrl_t'($urandom % 6);
      end else if (kind < 11) begin
         rs1D       = '0;
         immExtD    = word_t'(word << 2);
         regWriteD  = 1'b1;
         aluSrcD    = 1'b1;
         resultSrcD = RES_MEM;
      end else if (kind < 13) begin
         rs1D      = '0;
         rdD       = '0;
         immExtD   = word_t'(word << 2);
         memWriteD = 1'b1;
         aluSrcD   = 1'b1;
      end else if (kind < 15) begin
         // Equal sources half the time, so beq is often taken.
         if ($urandom % 2 == 0) begin
            rs2D = rs1D;
         end
         rdD         = '0;
         immExtD     = immExtD & ~32'd3;
         branchD     = 1'b1;
         aluControlD = ALU_SUB;
      end else begin
         immExtD    = immExtD & ~32'd3;
         jumpD      = 1'b1;
         regWriteD  = 1'b1;
         resultSrcD = RES_PC4;
      end
   endtask

   // Retire the presented instruction into the model.
   task automatic executeModel();
      word_t a;
      word_t b;
      word_t addr;
      word_t value;
      a     = modelRegs[rs1D];
      b     = modelRegs[rs2D];
      addr  = a + immExtD;
      value = expectedAlu(aluControlD, a, aluSrcD ? immExtD : b);
      if (resultSrcD == RES_MEM) begin
         value = modelMem[addr[5:2]];
      end else if (resultSrcD == RES_PC4) begin
         value = pcD + 32'd4;
      end
      if (memWriteD) begin
         modelMem[addr[5:2]] = b;
      end
      if (regWriteD && rdD != 5'd0) begin
         modelRegs[rdD] = value;
         expRd.push_back(rdD);
         expVal.push_back(value);
         expDue.push_back(cycle + 3);
      end
      redirectDue = jumpD || (branchD && a == b);
      targetDue   = pcD + immExtD;
      loadInE     = (resultSrcD == RES_MEM);
      rdInE       = rdD;
      pc          = pcD + 32'd4;
   endtask

   task automatic checkWriteback();
      if (expDue.size() > 0 && expDue[0] == cycle) begin
         assert (regWriteW && rdW == expRd[0] && resultW == expVal[0]) else
            reportError($sformatf("writeback %0b x%0d = %h, expected x%0d = %h",
                                  regWriteW, rdW, resultW, expRd[0], expVal[0]));
         void'(expRd.pop_front());
         void'(expVal.pop_front());
         void'(expDue.pop_front());
      end else begin
         assert (!regWriteW) else
            reportError($sformatf("unexpected writeback x%0d = %h", rdW, resultW));
      end
   endtask

   // One cycle: drive at the falling edge, decide from stallD and pcSrcE.
   task automatic presentCycle(input logic fresh, output logic done);
      logic stallExp;
      @(negedge clk);
      checkWriteback();
      if (fresh) begin
         if (draining) begin
            setBubble();
         end else begin
            randomizeInputs();
         end
         pcD = pc;
      end
      #1;
      stallExp = loadInE && rdInE != 5'd0 && (rdInE == rs1D || rdInE == rs2D);
      assert (pcSrcE == redirectDue) else
         reportError($sformatf("pcSrcE %0b, expected %0b", pcSrcE, redirectDue));
      if (redirectDue) begin
         assert (pcTargetE == targetDue) else
            reportError($sformatf("pcTargetE %h, expected %h", pcTargetE, targetDue));
      end
      assert (stallD == stallExp) else
         reportError($sformatf("stallD %0b, expected %0b", stallD, stallExp));
      if (pcSrcE) begin
         // Wrong-path instruction is dropped.
         done        = 1'b1;
         pc          = targetDue;
         redirectDue = 1'b0;
         loadInE     = 1'b0;
      end else if (stallD) begin
         done    = 1'b0;
         loadInE = 1'b0;
      end else begin
         done = 1'b1;
         executeModel();
      end
      @(posedge clk);
      cycle++;
   endtask

   initial begin
      logic done;
      int   attempts;
      int   drainCycles;
      void'($urandom(6));
      clk         = 1'b0;
      rst         = 1'b1;
      pcD         = '0;
      pc          = '0;
      cycle       = 0;
      draining    = 1'b0;
      loadInE     = 1'b0;
      rdInE       = '0;
      redirectDue = 1'b0;
      targetDue   = '0;
      setBubble();
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      for (int i = 0; i < 16; i++) begin
         modelMem[i] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (!regWriteW && !pcSrcE) else
         reportError("regWriteW or pcSrcE high after reset");

      for (int n = 0; n < NUM_INSTR; n++) begin
         attempts = 0;
         presentCycle(1'b1, done);
         while (!done) begin
            attempts++;
            if (attempts > MAX_STALL) begin
               reportTimeout($sformatf("instruction %0d never accepted", n));
            end
            presentCycle(1'b0, done);
         end
      end

      // Bubbles until every pending writeback has been seen.
      draining    = 1'b1;
      drainCycles = 0;
      while (expDue.size() > 0 || drainCycles < 3) begin
         drainCycles++;
         if (drainCycles > DRAIN_LIMIT) begin
            reportTimeout("pending writebacks never appeared");
         end
         presentCycle(1'b1, done);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* pipelineCore_checker.sv */
`timescale 1ns/1ps

module pipelineCore_checker import riscvCorePkg::*; (
   input logic     clk,
   input logic     rst,
   input logic     flushE,
   input logic     regWriteE,
   input logic     memWriteE,
   input logic     regWriteW,
   input regAddr_t rdW,
   input logic     stallD,
   input fwdSel_t  forwardA,
   input fwdSel_t  forwardB
);

   // Flushed execute stage must not write anything.
   flushMakesBubble: assert property (
      @(posedge clk) disable iff (rst) flushE |=> (!regWriteE && !memWriteE)
   ) else $error("execute stage kept a write enable after a flush");

   // Writes to x0 never reach writeback.
   noWritebackToZero: assert property (
      @(posedge clk) disable iff (rst) regWriteW |-> (rdW != 5'd0)
   ) else $error("writeback strobe with rdW equal to zero");

   stallKnown: assert property (
      @(posedge clk) disable iff (rst) !$isunknown(stallD)
   ) else $error("stallD is unknown");

   forwardKnown: assert property (
      @(posedge clk) disable iff (rst) !$isunknown({forwardA, forwardB})
   ) else $error("forward select is unknown");

endmodule

/* pipelineCore.sv */
`timescale 1ns/1ps

module pipelineCore import riscvCorePkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic       clk,
   input  logic       rst,
   input  regAddr_t   rs1D,
   input  regAddr_t   rs2D,
   input  regAddr_t   rdD,
   input  word_t      immExtD,
   input  word_t      pcD,
   input  logic       regWriteD,
   input  logic       aluSrcD,
   input  logic       memWriteD,
   input  logic       jumpD,
   input  logic       branchD,
   input  resultSel_t resultSrcD,
   input  aluCtrl_t   aluControlD,
   output logic       stallD,
   output logic       pcSrcE,
   output word_t      pcTargetE,
   output logic       regWriteW,
   output regAddr_t   rdW,
   output word_t      resultW
);

   word_t      rd1D;
   word_t      rd2D;
   word_t      rd1E;
   word_t      rd2E;
   regAddr_t   rs1E;
   regAddr_t   rs2E;
   regAddr_t   rdE;
   word_t      immExtE;
   word_t      pcE;
   logic       regWriteE;
   logic       aluSrcE;
   logic       memWriteE;
   logic       jumpE;
   logic       branchE;
   resultSel_t resultSrcE;
   aluCtrl_t   aluControlE;
   fwdSel_t    forwardA;
   fwdSel_t    forwardB;
   logic       flushE;
   word_t      aluResultM;
   word_t      writeDataM;
   word_t      pcPlus4M;
   regAddr_t   rdM;
   logic       regWriteM;
   logic       memWriteM;
   resultSel_t resultSrcM;

   registerFile regFile (
      .clk (clk),
      .rst (rst),
      .rs1 (rs1D),
      .rs2 (rs2D),
      .rd1 (rd1D),
      .rd2 (rd2D),
      .we  (regWriteW),
      .rd  (rdW),
      .wd  (resultW)
   );

   decodeExecuteReg deReg (
      .clk         (clk),
      .rst         (rst),
      .flush       (flushE),
      .rd1D        (rd1D),
      .rd2D        (rd2D),
      .rs1D        (rs1D),
      .rs2D        (rs2D),
      .rdD         (rdD),
      .immExtD     (immExtD),
      .pcD         (pcD),
      .regWriteD   (regWriteD),
      .aluSrcD     (aluSrcD),
      .memWriteD   (memWriteD),
      .jumpD       (jumpD),
      .branchD     (branchD),
      .resultSrcD  (resultSrcD),
      .aluControlD (aluControlD),
      .rd1E        (rd1E),
      .rd2E        (rd2E),
      .rs1E        (rs1E),
      .rs2E        (rs2E),
      .rdE         (rdE),
      .immExtE     (immExtE),
      .pcE         (pcE),
      .regWriteE   (regWriteE),
      .aluSrcE     (aluSrcE),
      .memWriteE   (memWriteE),
      .jumpE       (jumpE),
      .branchE     (branchE),
      .resultSrcE  (resultSrcE),
      .aluControlE (aluControlE)
   );

   executeStage exStage (
      .clk         (clk),
      .rst         (rst),
      .rd1E        (rd1E),
      .rd2E        (rd2E),
      .rdE         (rdE),
      .immExtE     (immExtE),
      .pcE         (pcE),
      .regWriteE   (regWriteE),
      .aluSrcE     (aluSrcE),
      .memWriteE   (memWriteE),
      .jumpE       (jumpE),
      .branchE     (branchE),
      .resultSrcE  (resultSrcE),
      .aluControlE (aluControlE),
      .resultW     (resultW),
      .forwardA    (forwardA),
      .forwardB    (forwardB),
      .aluResultM  (aluResultM),
      .writeDataM  (writeDataM),
      .pcPlus4M    (pcPlus4M),
      .pcTargetE   (pcTargetE),
      .rdM         (rdM),
      .regWriteM   (regWriteM),
      .memWriteM   (memWriteM),
      .resultSrcM  (resultSrcM),
      .pcSrcE      (pcSrcE)
   );

   memoryWritebackStage #(
      .MEM_WORDS (MEM_WORDS)
   ) mwStage (
      .clk        (clk),
      .rst        (rst),
      .aluResultM (aluResultM),
      .writeDataM (writeDataM),
      .pcPlus4M   (pcPlus4M),
      .rdM        (rdM),
      .regWriteM  (regWriteM),
      .memWriteM  (memWriteM),
      .resultSrcM (resultSrcM),
      .regWriteW  (regWriteW),
      .rdW        (rdW),
      .resultW    (resultW)
   );

   // Bit 0 of the result select marks a load in execute.
   hazardUnit hazards (
      .rs1D      (rs1D),
      .rs2D      (rs2D),
      .rs1E      (rs1E),
      .rs2E      (rs2E),
      .rdE       (rdE),
      .rdM       (rdM),
      .rdW       (rdW),
      .loadE     (resultSrcE[0]),
      .regWriteM (regWriteM),
      .regWriteW (regWriteW),
      .pcSrcE    (pcSrcE),
      .forwardA  (forwardA),
      .forwardB  (forwardB),
      .stallD    (stallD),
      .flushE    (flushE)
   );

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import riscvCorePkg::*; (
   input  regAddr_t rs1D,
   input  regAddr_t rs2D,
   input  regAddr_t rs1E,
   input  regAddr_t rs2E,
   input  regAddr_t rdE,
   input  regAddr_t rdM,
   input  regAddr_t rdW,
   input  logic     loadE,
   input  logic     regWriteM,
   input  logic     regWriteW,
   input  logic     pcSrcE,
   output fwdSel_t  forwardA,
   output fwdSel_t  forwardB,
   output logic     stallD,
   output logic     flushE
);

   // Youngest producer wins; x0 is never forwarded.
   function automatic fwdSel_t pickForward(input regAddr_t rs);
      if (regWriteM && rdM != 5'd0 && rdM == rs) begin
         return FWD_MEM;
      end
      if (regWriteW && rdW != 5'd0 && rdW == rs) begin
         return FWD_WB;
      end
      return FWD_REG;
   endfunction

   assign forwardA = pickForward(rs1E);
   assign forwardB = pickForward(rs2E);

   // Load result is not ready until writeback.
   assign stallD = loadE && (rdE != 5'd0) && (rdE == rs1D || rdE == rs2D);

   // Stall inserts a bubble; a redirect squashes the presented instruction.
   assign flushE = stallD || pcSrcE;

endmodule

/* memoryWritebackStage.sv */
`timescale 1ns/1ps

module memoryWritebackStage import riscvCorePkg::*; #(
   parameter int MEM_WORDS = 256
) (
   input  logic       clk,
   input  logic       rst,
   input  word_t      aluResultM,
   input  word_t      writeDataM,
   input  word_t      pcPlus4M,
   input  regAddr_t   rdM,
   input  logic       regWriteM,
   input  logic       memWriteM,
   input  resultSel_t resultSrcM,
   output logic       regWriteW,
   output regAddr_t   rdW,
   output word_t      resultW
);

   localparam int ADDR_BITS = $clog2(MEM_WORDS);

   word_t                 dataMem [MEM_WORDS];
   logic  [ADDR_BITS-1:0] wordIdx;
   word_t                 readDataM;
   word_t                 aluResultW;
   word_t                 readDataW;
   word_t                 pcPlus4W;
   resultSel_t            resultSrcW;

   // Word index, wrapping at the memory depth.
   assign wordIdx   = aluResultM[ADDR_BITS+1:2];
   assign readDataM = dataMem[wordIdx];

   // Unwritten words read as zero.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            dataMem[i] <= '0;
         end
      end else if (memWriteM) begin
         dataMem[wordIdx] <= writeDataM;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         regWriteW  <= 1'b0;
         resultSrcW <= RES_ALU;
         rdW        <= '0;
      end else begin
         regWriteW  <= regWriteM;
         resultSrcW <= resultSrcM;
         rdW        <= rdM;
      end
   end

   always_ff @(posedge clk) begin
      aluResultW <= aluResultM;
      readDataW  <= readDataM;
      pcPlus4W   <= pcPlus4M;
   end

   always_comb begin
      case (resultSrcW)
         RES_MEM: begin
            resultW = readDataW;
         end
         RES_PC4: begin
            resultW = pcPlus4W;
         end
         default: begin
            resultW = aluResultW;
         end
      endcase
   end

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage import riscvCorePkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  word_t      rd1E,
   input  word_t      rd2E,
   input  regAddr_t   rdE,
   input  word_t      immExtE,
   input  word_t      pcE,
   input  logic       regWriteE,
   input  logic       aluSrcE,
   input  logic       memWriteE,
   input  logic       jumpE,
   input  logic       branchE,
   input  resultSel_t resultSrcE,
   input  aluCtrl_t   aluControlE,
   input  word_t      resultW,
   input  fwdSel_t    forwardA,
   input  fwdSel_t    forwardB,
   output word_t      aluResultM,
   output word_t      writeDataM,
   output word_t      pcPlus4M,
   output word_t      pcTargetE,
   output regAddr_t   rdM,
   output logic       regWriteM,
   output logic       memWriteM,
   output resultSel_t resultSrcM,
   output logic       pcSrcE
);

   word_t srcA;
   word_t fwdB;
   word_t srcB;
   word_t aluResultE;
   logic  zeroE;

   // Operand source after forwarding.
   function automatic word_t pickOperand(input fwdSel_t sel, input word_t regValue);
      case (sel)
         FWD_WB: begin
            return resultW;
         end
         FWD_MEM: begin
            return aluResultM;
         end
         default: begin
            return regValue;
         end
      endcase
   endfunction

   assign srcA = pickOperand(forwardA, rd1E);
   assign fwdB = pickOperand(forwardB, rd2E);

   // Immediate replaces B; store data keeps the forwarded register.
   assign srcB = aluSrcE ? immExtE : fwdB;

   aluUnit alu (
      .a          (srcA),
      .b          (srcB),
      .aluControl (aluControlE),
      .result     (aluResultE),
      .zero       (zeroE)
   );

   assign pcTargetE = pcE + immExtE;
   assign pcSrcE    = (branchE && zeroE) || jumpE;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         regWriteM  <= 1'b0;
         memWriteM  <= 1'b0;
         resultSrcM <= RES_ALU;
         rdM        <= '0;
      end else begin
         regWriteM  <= regWriteE;
         memWriteM  <= memWriteE;
         resultSrcM <= resultSrcE;
         rdM        <= rdE;
      end
   end

   always_ff @(posedge clk) begin
      aluResultM <= aluResultE;
      writeDataM <= fwdB;
      pcPlus4M   <= pcE + 32'd4;
   end

endmodule

/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import riscvCorePkg::*; (
   input  word_t    a,
   input  word_t    b,
   input  aluCtrl_t aluControl,
   output word_t    result,
   output logic     zero
);

   logic lessThan;

   // Signed compare for slt.
   assign lessThan = $signed(a) < $signed(b);

   always_comb begin
      case (aluControl)
         ALU_ADD: begin
            result = a + b;
         end
         ALU_SUB: begin
            result = a - b;
         end
         ALU_AND: begin
            result = a & b;
         end
         ALU_OR: begin
            result = a | b;
         end
         ALU_XOR: begin
            result = a ^ b;
         end
         ALU_SLT: begin
            result = {31'd0, lessThan};
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // beq uses sub, so zero means equal operands.
   assign zero = (result == '0);

endmodule

/* decodeExecuteReg.sv */
`timescale 1ns/1ps

module decodeExecuteReg import riscvCorePkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       flush,
   input  word_t      rd1D,
   input  word_t      rd2D,
   input  regAddr_t   rs1D,
   input  regAddr_t   rs2D,
   input  regAddr_t   rdD,
   input  word_t      immExtD,
   input  word_t      pcD,
   input  logic       regWriteD,
   input  logic       aluSrcD,
   input  logic       memWriteD,
   input  logic       jumpD,
   input  logic       branchD,
   input  resultSel_t resultSrcD,
   input  aluCtrl_t   aluControlD,
   output word_t      rd1E,
   output word_t      rd2E,
   output regAddr_t   rs1E,
   output regAddr_t   rs2E,
   output regAddr_t   rdE,
   output word_t      immExtE,
   output word_t      pcE,
   output logic       regWriteE,
   output logic       aluSrcE,
   output logic       memWriteE,
   output logic       jumpE,
   output logic       branchE,
   output resultSel_t resultSrcE,
   output aluCtrl_t   aluControlE
);

   // Control bits. A flush turns the stage into a bubble.
   always_ff @(posedge clk or posedge rst) begin
      if (rst || flush) begin
         regWriteE   <= 1'b0;
         aluSrcE     <= 1'b0;
         memWriteE   <= 1'b0;
         jumpE       <= 1'b0;
         branchE     <= 1'b0;
         resultSrcE  <= RES_ALU;
         aluControlE <= ALU_ADD;
      end else begin
         // Writes to x0 are dropped here.
         regWriteE   <= regWriteD && (rdD != 5'd0);
         aluSrcE     <= aluSrcD;
         memWriteE   <= memWriteD;
         jumpE       <= jumpD;
         branchE     <= branchD;
         resultSrcE  <= resultSrcD;
         aluControlE <= aluControlD;
      end
   end

   // Register indices feed the hazard unit.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rs1E <= '0;
         rs2E <= '0;
         rdE  <= '0;
      end else begin
         rs1E <= rs1D;
         rs2E <= rs2D;
         rdE  <= rdD;
      end
   end

   always_ff @(posedge clk) begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      immExtE <= immExtD;
      pcE     <= pcD;
   end

endmodule

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile import riscvCorePkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  regAddr_t rs1,
   input  regAddr_t rs2,
   output word_t    rd1,
   output word_t    rd2,
   input  logic     we,
   input  regAddr_t rd,
   input  word_t    wd
);

   word_t regs [32];

   // One read port, with x0 forced and the write data bypassed.
   function automatic word_t readPort(input regAddr_t addr);
      if (addr == 5'd0) begin
         return '0;
      end
      if (we && rd == addr) begin
         return wd;
      end
      return regs[addr];
   endfunction

   assign rd1 = readPort(rs1);
   assign rd2 = readPort(rs2);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != 5'd0) begin
         regs[rd] <= wd;
      end
   end

endmodule

/* riscvCorePkg.sv */
package riscvCorePkg;

   // Data, address and PC values.
   typedef logic [31:0] word_t;

   // Register index.
   typedef logic [4:0] regAddr_t;

   // ALU operation.
   typedef logic [2:0] aluCtrl_t;

   // Writeback source. Bit 0 marks a load.
   typedef logic [1:0] resultSel_t;

   // Forwarding source for an execute operand.
   typedef logic [1:0] fwdSel_t;

   localparam aluCtrl_t ALU_ADD = 3'b000;
   localparam aluCtrl_t ALU_SUB = 3'b001;
   localparam aluCtrl_t ALU_AND = 3'b010;
   localparam aluCtrl_t ALU_OR  = 3'b011;
   localparam aluCtrl_t ALU_XOR = 3'b100;
   localparam aluCtrl_t ALU_SLT = 3'b101;

   localparam resultSel_t RES_ALU = 2'b00;
   localparam resultSel_t RES_MEM = 2'b01;
   localparam resultSel_t RES_PC4 = 2'b10;

   // Register value, writeback result, memory-stage ALU result.
   localparam fwdSel_t FWD_REG = 2'b00;
   localparam fwdSel_t FWD_WB  = 2'b01;
   localparam fwdSel_t FWD_MEM = 2'b10;

endpackage
